//--- rtl/hisBuilder_settings.svh
`ifndef HISBUILDER_SETTINGS_SVH
`define HISBUILDER_SETTINGS_SVH

// ##########################################################################
// Sample format
// ##########################################################################

`define Np 10                 // Bits per raw sample.

// ##########################################################################
// Pixel geometry
// ##########################################################################

// One acquisition is ROWS rows of PIXEL_NUM_PER_RAM pixels.
`define ROWS 2
`define PIXEL_NUM_PER_RAM 3
`define PIXEL_NUM 6           // ROWS * PIXEL_NUM_PER_RAM.

// ##########################################################################
// Histogram shape
// ##########################################################################

`define BIN_BITS 3            // Top bits of the pixel code, 8 bins.
`define COUNT_WIDTH 4         // Counters stop at 15.

// Events that may be in flight between the sequencer and the memory.
// Two covers the read-modify-write round trip at one sample per cycle.
`define CREDITS 2

`endif

//--- rtl/hisBuilderPkg.sv
`include "hisBuilder_settings.svh"

package hisBuilderPkg;

    // ######################################################################
    // Data widths
    // ######################################################################

    typedef logic [`Np-1:0]          sample_t;      // One raw sample.
    typedef logic [2:0]              pixelIndex_t;  // Pixel 0 to 5.
    typedef logic [`BIN_BITS-1:0]    binIndex_t;
    typedef logic [`COUNT_WIDTH-1:0] binCount_t;    // Saturating counter.
    typedef logic [1:0]              credit_t;      // Holds 0 to `CREDITS.

    // ######################################################################
    // State machines
    // ######################################################################

    // Sample pairing in the sequencer.
    typedef enum logic {
        FIRST_SAMPLE,
        SECOND_SAMPLE
    } acqState_t;

    // Clear sweep in the memory.
    typedef enum logic {
        CLEARING,
        RUNNING
    } ramState_t;

endpackage

//--- rtl/binEventIf.sv
`timescale 1ns/100ps

// Bin events from the sequencer, credits back from the memory.
interface binEventIf import hisBuilderPkg::*; (
    input logic clk
);

    logic        eventValid;     // One cycle per event.
    pixelIndex_t eventPixel;
    binIndex_t   eventBin;
    logic        creditReturn;   // One cycle per counter write.

    modport source (
        input  clk,
        output eventValid,
        output eventPixel,
        output eventBin,
        input  creditReturn
    );

    // No ready here, every event is taken.
    modport sink (
        input  clk,
        input  eventValid,
        input  eventPixel,
        input  eventBin,
        output creditReturn
    );

endinterface

//--- rtl/acquisitionFsm.sv
`timescale 1ns/100ps
`include "hisBuilder_settings.svh"

module acquisitionFsm import hisBuilderPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wrEn,
    input  sample_t   data,
    input  logic      restart,      // High for the whole memory sweep.
    output logic      overflow,
    output logic      busy,
    binEventIf.source ev
);

    acqState_t     state;
    pixelIndex_t   row;
    pixelIndex_t   col;
    sample_t       firstSample;
    credit_t       credits;
    logic          pendValid;
    pixelIndex_t   pendPixel;
    binIndex_t     pendBin;

    logic          take;
    logic          newEvent;
    logic          issue;
    logic [`Np:0]  pairSum;
    sample_t       average;
    binIndex_t     binNow;
    pixelIndex_t   pixelNow;

    assign take     = wrEn && !restart;               // Samples are ignored during a sweep.
    assign newEvent = take && (state == SECOND_SAMPLE);
    assign issue    = (credits != '0) && (pendValid || newEvent);

    // Pixel code is the mean of the pair.
    assign pairSum  = {1'b0, firstSample} + {1'b0, data};
    assign average  = pairSum[`Np:1];
    assign binNow   = average[`Np-1 -: `BIN_BITS];
    assign pixelNow = pixelIndex_t'(row * `PIXEL_NUM_PER_RAM) + col;

    assign busy = pendValid || (credits != credit_t'(`CREDITS));

    // ######################################################################
    // Row, pixel and sample counters
    // ######################################################################

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            state <= FIRST_SAMPLE;
            row   <= '0;
            col   <= '0;
        end else if (take) begin
            if (state == FIRST_SAMPLE) begin
                state <= SECOND_SAMPLE;
            end else begin
                state <= FIRST_SAMPLE;
                if (col == pixelIndex_t'(`PIXEL_NUM_PER_RAM - 1)) begin
                    col <= '0;
                    row <= (row == pixelIndex_t'(`ROWS - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // ######################################################################
    // Credits and the pending slot
    // ######################################################################

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            credits       <= credit_t'(`CREDITS);
            pendValid     <= 1'b0;
            ev.eventValid <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            credits       <= credits - credit_t'(issue) + credit_t'(ev.creditReturn);
            ev.eventValid <= issue;
            if (pendValid) begin
                if (issue)
                    pendValid <= newEvent;             // Refilled by the newcomer.
                else if (newEvent)
                    overflow <= 1'b1;                  // Slot full, event lost.
            end else if (newEvent && !issue) begin
                pendValid <= 1'b1;
            end
        end
    end

    // Pending events leave first, so order is kept.
    always_ff @(posedge clk) begin
        if (take && (state == FIRST_SAMPLE))
            firstSample <= data;
        if (issue) begin
            ev.eventPixel <= pendValid ? pendPixel : pixelNow;
            ev.eventBin   <= pendValid ? pendBin : binNow;
        end
        // New event parks when the slot is free after this edge.
        if (newEvent && (pendValid == issue)) begin
            pendPixel <= pixelNow;
            pendBin   <= binNow;
        end
    end

endmodule

//--- rtl/histogramRam.sv
`timescale 1ns/100ps
`include "hisBuilder_settings.svh"

module histogramRam import hisBuilderPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    binEventIf.sink     ev,
    input  pixelIndex_t readPixel,
    input  binIndex_t   readBin,
    output binCount_t   readCount,
    output logic        clearing
);

    localparam int ADDR_W = $bits(pixelIndex_t) + `BIN_BITS;
    localparam int DEPTH  = `PIXEL_NUM << `BIN_BITS;     // 48 counters.

    binCount_t         mem [DEPTH];
    ramState_t         state;
    logic [ADDR_W-1:0] clearAddr;

    // Read stage.
    logic              rdValid;
    logic [ADDR_W-1:0] rdAddr;
    binCount_t         rdData;

    // Write stage.
    logic              wrValid;
    logic [ADDR_W-1:0] wrAddr;
    binCount_t         wrData;

    binCount_t         curCount;
    binCount_t         nextCount;

    assign clearing = (state == CLEARING);

    // Previous event to the same counter is still in the write stage.
    assign curCount  = (wrValid && (wrAddr == rdAddr)) ? wrData : rdData;
    assign nextCount = (curCount == '1) ? curCount : curCount + 1'b1;

    assign ev.creditReturn = wrValid;

    // ######################################################################
    // Sweep control and pipeline valids
    // ######################################################################

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            state     <= CLEARING;
            clearAddr <= '0;
            rdValid   <= 1'b0;                // In-flight events are dropped.
            wrValid   <= 1'b0;
        end else begin
            rdValid <= ev.eventValid && (state == RUNNING);
            wrValid <= rdValid;
            if (state == CLEARING) begin
                clearAddr <= clearAddr + 1'b1;
                if (clearAddr == ADDR_W'(DEPTH - 1))
                    state <= RUNNING;
            end
        end
    end

    // ######################################################################
    // Counter array
    // ######################################################################

    // Zero one counter per cycle while sweeping, else commit the increment.
    always_ff @(posedge clk) begin
        if (state == CLEARING)
            mem[clearAddr] <= '0;
        else if (rdValid)
            mem[rdAddr] <= nextCount;
    end

    always_ff @(posedge clk) begin
        rdAddr <= {ev.eventPixel, ev.eventBin};
        rdData <= mem[{ev.eventPixel, ev.eventBin}];
        wrAddr <= rdAddr;
        wrData <= nextCount;
    end

    // Readout port, one cycle latency.
    always_ff @(posedge clk) begin
        readCount <= mem[{readPixel, readBin}];
    end

endmodule

//--- rtl/hisBuilder.sv
`timescale 1ns/100ps

module hisBuilder import hisBuilderPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wrEn,
    input  sample_t     data,
    input  logic        clear,        // One-cycle pulse starts a sweep.
    input  pixelIndex_t readPixel,
    input  binIndex_t   readBin,
    output binCount_t   readCount,
    output logic        idle,
    output logic        overflow
);

    logic clearing;
    logic busy;

    // ######################################################################
    // Sequencer to memory link
    // ######################################################################

    binEventIf binLink (
        .clk (clk)
    );

    acquisitionFsm acquisitionFsm_inst (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (wrEn),
        .data     (data),
        .restart  (clearing),      // Sweep restarts at row 0, pixel 0.
        .overflow (overflow),
        .busy     (busy),
        .ev       (binLink.source)
    );

    histogramRam histogramRam_inst (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .ev        (binLink.sink),
        .readPixel (readPixel),
        .readBin   (readBin),
        .readCount (readCount),
        .clearing  (clearing)
    );

    // Readout is valid once the sweep is done and all credits are home.
    assign idle = !clearing && !busy;

endmodule

//--- tests/hisBuilderTb.sv
`timescale 1ns/100ps
`include "hisBuilder_settings.svh"

module hisBuilderTb import hisBuilderPkg::*; ();

    localparam string TRACE_FILE = "tests/hisBuilderTrace.txt";
    localparam int RESET_CYCLES  = 16;
    localparam int SWEEP_CYCLES  = `PIXEL_NUM << `BIN_BITS;
    localparam int IDLE_WAIT     = 64;                // Cycles an I record may wait.
    localparam int ACQ_SAMPLES   = 2 * `PIXEL_NUM;    // Two samples per pixel.

    logic        clk = 1'b0;
    logic        reset;
    logic        wrEn;
    sample_t     data;
    logic        clear;
    pixelIndex_t readPixel;
    binIndex_t   readBin;
    binCount_t   readCount;
    logic        idle;
    logic        overflow;

    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    testStartErrors = 0;
    int    cycleCount = 0;
    int    cycleLimit = 1_000_000;                    // Replaced once the trace is counted.
    int    lastAcq[$];                                // Samples of the latest acquisition.
    string testName;

    hisBuilder hisBuilder_inst (
        .clk       (clk),
        .reset     (reset),
        .wrEn      (wrEn),
        .data      (data),
        .clear     (clear),
        .readPixel (readPixel),
        .readBin   (readBin),
        .readCount (readCount),
        .idle      (idle),
        .overflow  (overflow)
    );

    always #5 clk = ~clk;

    // Stops a run that never reaches the end of the trace.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Run stopped after %0d cycles before the trace was done", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ######################################################################
    // Stimulus and checks
    // ######################################################################

    // Inputs change 1 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic driveCycle(input logic wr, input int value, input logic clr);
        wrEn  = wr;
        data  = sample_t'(value);
        clear = clr;
        step();
        wrEn  = 1'b0;
        clear = 1'b0;
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        while (!idle && waited < IDLE_WAIT) begin
            step();
            waited++;
        end
        if (!idle) begin
            $display("Time %0t: idle did not rise within %0d cycles", $time, IDLE_WAIT);
            errors++;
        end
        if (overflow !== 1'b0) begin
            $display("ERROR at %0t: overflow expected 0, got %b", $time, overflow);
            errors++;
        end
    endtask

    // One cycle of read latency.
    task automatic checkCount(input int pix, input int bin, input int expected);
        readPixel = pixelIndex_t'(pix);
        readBin   = binIndex_t'(bin);
        step();
        checks++;
        if (readCount !== binCount_t'(expected)) begin
            $display("ERROR at %0t: readCount pixel %0d bin %0d expected %0d, got %0d",
                     $time, pix, bin, expected, readCount);
            errors++;
        end
    endtask

    // A dry pass only counts the records for the cycle limit.
    task automatic runTrace(input bit dryRun, output int records);
        int fd;
        int code;
        int want;
        int ch;
        int a;
        int b;
        int c;
        string cmd;
        records = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Trace file %s could not be opened", TRACE_FILE);
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            records++;
            code = 0;
            want = 0;
            if (cmd == "#") begin
                records--;
                do
                    ch = $fgetc(fd);
                while (ch != 10 && ch != -1);
            end else if (cmd == "T") begin
                want = 1;
                code = $fscanf(fd, "%s", testName);
                testStartErrors = errors;
            end else if (cmd == "W") begin
                want = 1;
                code = $fscanf(fd, "%d", a);
                if (!dryRun) begin
                    driveCycle(1'b1, a, 1'b0);
                    lastAcq.push_back(a);
                    if (lastAcq.size() > ACQ_SAMPLES)
                        void'(lastAcq.pop_front());
                end
            end else if (cmd == "G") begin
                if (!dryRun)
                    driveCycle(1'b0, 0, 1'b0);
            end else if (cmd == "C") begin
                if (!dryRun)
                    driveCycle(1'b0, 0, 1'b1);
            end else if (cmd == "P") begin
                want = 1;
                code = $fscanf(fd, "%d", a);
                records += a * ACQ_SAMPLES;
                if (!dryRun) begin
                    repeat (a) begin
                        foreach (lastAcq[i])
                            driveCycle(1'b1, lastAcq[i], 1'b0);
                    end
                end
            end else if (cmd == "I") begin
                if (!dryRun)
                    waitIdle();
            end else if (cmd == "R") begin
                want = 3;
                code = $fscanf(fd, "%d %d %d", a, b, c);
                if (!dryRun)
                    checkCount(a, b, c);
            end else if (cmd == "E") begin
                if (!dryRun) begin
                    tests++;
                    $display("Test %s finished with %0d errors", testName,
                             errors - testStartErrors);
                end
            end else begin
                $display("Trace record %s is not known", cmd);
                errors++;
            end
            if (!dryRun && code != want) begin
                $display("Trace record %s has %0d of its %0d fields", cmd, code, want);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // ######################################################################
    // Main sequence
    // ######################################################################

    initial begin
        int records;
        reset     = 1'b1;
        wrEn      = 1'b0;
        data      = '0;
        clear     = 1'b0;
        readPixel = '0;
        readBin   = '0;
        runTrace(1'b1, records);
        cycleLimit = records * IDLE_WAIT + RESET_CYCLES + SWEEP_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        runTrace(1'b0, records);
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- tests/hisBuilderTrace.txt
# Records: T name | W sample | G | C | P times | I | R pixel bin expected | E
# Pixels go row-major with two W each; the bin is the top 3 bits of the pair average.
T reset
I  R 0 0 0  R 3 4 0  R 5 7 0
E
T single
W 0 W 20  W 130 W 140  W 300 W 310
W 1023 W 1023  W 600 W 601  W 900 W 700
I  R 0 0 1  R 1 1 1  R 2 2 1  R 0 1 0
R 3 7 1  R 4 4 1  R 5 6 1
E
T accumulate
W 10 W 12  W 200 W 250  W 500 W 520
W 1000 W 1020  W 640 W 650  W 770 W 790
I  R 0 0 2  R 1 1 2  R 2 2 1  R 2 3 1
R 3 7 2  R 4 4 1  R 4 5 1  R 5 6 2
E
T saturate
P 20
I  R 0 0 15  R 2 3 15  R 2 2 1  R 4 5 15  R 4 4 1
E
T gaps
W 256 G W 384  W 1023 G G W 0  W 300 W 310 G
G W 100 G W 200  W 600 G W 601  W 128 W 128
I  R 0 2 1  R 1 3 1  R 2 2 2
R 3 1 1  R 4 4 2  R 5 1 1
E
T clear
W 10 W 20 W 30
C
I  R 0 0 0  R 2 3 0  R 4 5 0
W 900 W 910 W 50 W 60
I  R 0 7 1  R 1 0 1  R 1 3 0
E

//--- hisBuilder.f
+incdir+rtl
rtl/hisBuilderPkg.sv
rtl/binEventIf.sv
rtl/acquisitionFsm.sv
rtl/histogramRam.sv
rtl/hisBuilder.sv
tests/hisBuilderTb.sv

//--- Makefile
SIM       = verilator
FLAGS     = --binary --timing
TOP       = hisBuilderTb
FILELIST  = hisBuilder.f
BUILD_DIR = obj_dir

SOURCES = $(shell grep -v '^+' $(FILELIST)) rtl/hisBuilder_settings.svh
BINARY  = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(BUILD_DIR)
